//--- hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Cache geometry
`define FETCH_OFFSET_BITS 4
`define FETCH_INDEX_BITS 2
`define FETCH_TAG_BITS 26
`define FETCH_LINE_WORDS 4

// arlen for a full line fill
`define FETCH_BURST_LEN 8'd3

`define FETCH_RESET_PC 32'h3000_0000

// Top address byte of the uncached SRAM region
`define FETCH_SRAM_TAG 8'h0F

// Unblocked cycles until a misaligned PC is reported
`define FETCH_MISALIGN_DELAY 4

`endif

//--- hw/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // Byte address
  typedef logic [31:0] addr_t;

  typedef logic [31:0] inst_t;

  // Word 0 sits in the low bits
  typedef logic [`FETCH_LINE_WORDS*32-1:0] line_t;

  typedef logic [`FETCH_TAG_BITS-1:0] tag_t;

  typedef enum logic [1:0] {
    LOOKUP,
    REQUEST,
    RECEIVE
  } fetch_state_e;

endpackage

`default_nettype wire

//--- hw/axi_read_if.sv
`default_nettype none

interface axi_read_if;

  fetch_pkg::addr_t araddr;
  logic             arvalid;
  logic [7:0]       arlen;
  logic             arready;
  fetch_pkg::inst_t rdata;
  logic [1:0]       rresp;
  logic             rvalid;
  logic             rlast;
  logic             rready;

  modport master (
    output araddr, arvalid, arlen, rready,
    input  arready, rdata, rresp, rvalid, rlast
  );

  modport slave (
    input  araddr, arvalid, arlen, rready,
    output arready, rdata, rresp, rvalid, rlast
  );

endinterface

`default_nettype wire

//--- hw/icache_port_if.sv
`default_nettype none

interface icache_port_if;

  fetch_pkg::addr_t lookup_pc;
  logic             hit;
  fetch_pkg::inst_t hit_word;
  logic             fill_valid;
  fetch_pkg::inst_t fill_word;
  logic             fill_last;

  modport ctrl (
    output lookup_pc, fill_valid, fill_word, fill_last,
    input  hit, hit_word
  );

  modport array (
    input  lookup_pc, fill_valid, fill_word, fill_last,
    output hit, hit_word
  );

endinterface

`default_nettype wire

//--- hw/icache_array.sv
`default_nettype none

`include "fetch_macros.svh"

module icache_array (
  input wire          clock,
  input wire          reset,
  input wire          clear_cache,
  icache_port_if.array port
);

  localparam int LINES = 1 << `FETCH_INDEX_BITS;
  localparam int LINE_BITS = `FETCH_LINE_WORDS * 32;

  logic [LINES-1:0]  valid;
  fetch_pkg::tag_t   tags [LINES];
  fetch_pkg::line_t  data [LINES];

  logic [`FETCH_INDEX_BITS-1:0] index;
  logic [`FETCH_OFFSET_BITS-3:0] word_sel;
  fetch_pkg::tag_t   pc_tag;
  fetch_pkg::line_t  line;
  logic              is_sram;

  assign index    = port.lookup_pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign word_sel = port.lookup_pc[`FETCH_OFFSET_BITS-1:2];
  assign pc_tag   = port.lookup_pc[31 -: `FETCH_TAG_BITS];
  assign is_sram  = port.lookup_pc[31:24] == `FETCH_SRAM_TAG;
  assign line     = data[index];

  // Uncached region never hits
  assign port.hit      = valid[index] && (tags[index] == pc_tag) && !is_sram;
  assign port.hit_word = line[word_sel*32 +: 32];

  always_ff @(posedge clock) begin
    if (reset || clear_cache) begin
      valid <= '0;
    end else if (port.fill_valid) begin
      // Partly filled line must not hit
      valid[index] <= port.fill_last;
    end
  end

  always_ff @(posedge clock) begin
    if (port.fill_valid) begin
      // Beats enter at the top, so word 0 ends up lowest
      data[index] <= {port.fill_word, data[index][LINE_BITS-1:32]};
      if (port.fill_last) begin
        tags[index] <= pc_tag;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/fetch_ctrl.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
  input wire              clock,
  input wire              reset,
  input fetch_pkg::addr_t npc,
  input wire              npc_valid,
  input wire              clear_pipeline,
  input wire              idu_ready,
  input wire              block,
  output logic            inst_valid,
  output fetch_pkg::inst_t inst,
  output fetch_pkg::addr_t ifu_pc,
  output logic            busy,
  output logic            inst_addr_misaligned,
  axi_read_if.master      axi,
  icache_port_if.ctrl     cache
);

  localparam int DELAY = `FETCH_MISALIGN_DELAY;

  fetch_pkg::fetch_state_e state;
  fetch_pkg::addr_t        pc;
  logic                    pipeline_empty;
  logic                    stale;
  logic [DELAY-1:0]        misalign_q;

  logic pc_sram;
  logic req_sram;
  logic misaligned;
  logic lookup_go;
  logic can_start;
  logic hit_issue;
  logic start_miss;
  logic issue_req;
  logic misalign_now;
  logic beat;
  logic sram_issue;

  assign pc_sram    = pc[31:24] == `FETCH_SRAM_TAG;
  assign req_sram   = axi.araddr[31:24] == `FETCH_SRAM_TAG;
  assign misaligned = pc[1:0] != 2'b00;
  assign lookup_go  = (state == fetch_pkg::LOOKUP) && !block && idu_ready && !clear_pipeline;

  // Only fetch on a miss when the PC is known to be on the real path
  assign can_start  = pipeline_empty || (npc_valid && (npc == pc));

  assign hit_issue    = lookup_go && cache.hit && !misaligned;
  assign start_miss   = lookup_go && !(cache.hit && !misaligned) && can_start;
  assign issue_req    = start_miss && !misaligned;
  assign misalign_now = start_miss && misaligned;

  assign beat       = (state == fetch_pkg::RECEIVE) && axi.rvalid && axi.rready;
  assign sram_issue = beat && req_sram && !stale && !clear_pipeline;

  // During a miss the array is indexed by the request address
  assign cache.lookup_pc  = (state == fetch_pkg::LOOKUP) ? pc : axi.araddr;
  assign cache.fill_valid = beat && !req_sram;
  assign cache.fill_word  = axi.rdata;
  assign cache.fill_last  = axi.rlast;

  assign busy                 = state != fetch_pkg::LOOKUP;
  assign inst_addr_misaligned = misalign_q[DELAY-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= fetch_pkg::LOOKUP;
      pc             <= `FETCH_RESET_PC;
      ifu_pc         <= `FETCH_RESET_PC;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      stale          <= 1'b0;
      misalign_q     <= '0;
      axi.arvalid    <= 1'b0;
      axi.rready     <= 1'b0;
    end else begin
      if (clear_pipeline) begin
        pc             <= npc;
        inst_valid     <= 1'b0;
        pipeline_empty <= 1'b1;
        misalign_q     <= '0;
      end else begin
        if (!block) begin
          misalign_q <= {misalign_q[DELAY-2:0], misalign_q[0] | misalign_now};
        end
        if (hit_issue) begin
          inst_valid     <= 1'b1;
          ifu_pc         <= pc;
          pc             <= pc + 32'd4;
          pipeline_empty <= 1'b0;
        end else if (lookup_go) begin
          inst_valid <= 1'b0;
          if (misalign_now) begin
            ifu_pc <= pc;
          end
        end else if (sram_issue) begin
          inst_valid     <= 1'b1;
          ifu_pc         <= axi.araddr;
          pc             <= axi.araddr + 32'd4;
          pipeline_empty <= 1'b0;
        end
      end

      // A redirect mid-miss makes the outstanding word useless
      if (state == fetch_pkg::LOOKUP) begin
        stale <= 1'b0;
      end else if (clear_pipeline) begin
        stale <= 1'b1;
      end

      case (state)
        fetch_pkg::LOOKUP: begin
          if (issue_req) begin
            axi.arvalid <= 1'b1;
            state       <= fetch_pkg::REQUEST;
          end
        end
        fetch_pkg::REQUEST: begin
          if (axi.arready) begin
            axi.arvalid <= 1'b0;
            axi.rready  <= 1'b1;
            state       <= fetch_pkg::RECEIVE;
          end
        end
        fetch_pkg::RECEIVE: begin
          if (beat && axi.rlast) begin
            axi.rready <= 1'b0;
            state      <= fetch_pkg::LOOKUP;
          end
        end
        default: state <= fetch_pkg::LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (hit_issue) begin
      inst <= cache.hit_word;
    end else if (sram_issue) begin
      inst <= axi.rdata;
    end
    if (issue_req) begin
      if (pc_sram) begin
        axi.araddr <= pc;
        axi.arlen  <= 8'd0;
      end else begin
        axi.araddr <= {pc[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};
        axi.arlen  <= `FETCH_BURST_LEN;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`default_nettype none

module fetch_top (
  input wire               clock,
  input wire               reset,
  input fetch_pkg::addr_t  npc,
  input wire               npc_valid,
  input wire               clear_pipeline,
  input wire               clear_cache,
  input wire               idu_ready,
  input wire               block,
  output logic             inst_valid,
  output fetch_pkg::inst_t inst,
  output fetch_pkg::addr_t ifu_pc,
  output logic             busy,
  output logic             inst_addr_misaligned,
  output fetch_pkg::addr_t araddr,
  output logic             arvalid,
  output logic [7:0]       arlen,
  input wire               arready,
  output logic             rready,
  input fetch_pkg::inst_t  rdata,
  input wire [1:0]         rresp,
  input wire               rvalid,
  input wire               rlast
);

  axi_read_if    axi ();
  icache_port_if cache_port ();

  // AXI read channels out to plain ports
  assign araddr      = axi.araddr;
  assign arvalid     = axi.arvalid;
  assign arlen       = axi.arlen;
  assign rready      = axi.rready;
  assign axi.arready = arready;
  assign axi.rdata   = rdata;
  assign axi.rresp   = rresp;
  assign axi.rvalid  = rvalid;
  assign axi.rlast   = rlast;

  fetch_ctrl i_ctrl (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .clear_pipeline       (clear_pipeline),
    .idu_ready            (idu_ready),
    .block                (block),
    .inst_valid           (inst_valid),
    .inst                 (inst),
    .ifu_pc               (ifu_pc),
    .busy                 (busy),
    .inst_addr_misaligned (inst_addr_misaligned),
    .axi                  (axi.master),
    .cache                (cache_port.ctrl)
  );

  icache_array i_array (
    .clock       (clock),
    .reset       (reset),
    .clear_cache (clear_cache),
    .port        (cache_port.array)
  );

endmodule

`default_nettype wire

//--- dv/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
  input wire               clock,
  input fetch_pkg::addr_t  araddr,
  input wire               arvalid,
  input wire [7:0]         arlen,
  output logic             arready,
  output fetch_pkg::inst_t rdata,
  output logic [1:0]       rresp,
  output logic             rvalid,
  output logic             rlast,
  input wire               rready,
  output int               request_count
);

  localparam int READY_LIMIT = 50;

  fetch_pkg::addr_t base;
  int               beats;

  initial begin
    void'($urandom(76));
    arready       = 1'b0;
    rdata         = '0;
    rresp         = 2'b00;
    rvalid        = 1'b0;
    rlast         = 1'b0;
    request_count = 0;
    forever begin
      @(negedge clock);
      if (arvalid) begin
        base  = araddr;
        beats = int'(arlen) + 1;
        repeat ($urandom % 4) @(negedge clock);
        arready = 1'b1;
        @(negedge clock);
        arready = 1'b0;
        request_count++;
        for (int i = 0; i < beats; i++) begin
          // Gap of 0 to 3 cycles before each beat
          repeat ($urandom % 4) @(negedge clock);
          for (int t = 0; t < READY_LIMIT && !rready; t++) begin
            @(negedge clock);
          end
          rvalid = 1'b1;
          rlast  = (i == beats - 1);
          rdata  = (base + 4 * i) ^ 32'hA5A5_0000;
          @(negedge clock);
          rvalid = 1'b0;
          rlast  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/fetch_tb.sv
`default_nettype none

module fetch_tb;

  localparam int WAIT_LIMIT = 200;

  logic             clock = 1'b0;
  logic             reset;
  fetch_pkg::addr_t npc;
  logic             npc_valid;
  logic             clear_pipeline;
  logic             clear_cache;
  logic             idu_ready;
  logic             block;
  logic             inst_valid;
  fetch_pkg::inst_t inst;
  fetch_pkg::addr_t ifu_pc;
  logic             busy;
  logic             inst_addr_misaligned;
  fetch_pkg::addr_t araddr;
  logic             arvalid;
  logic [7:0]       arlen;
  logic             arready;
  logic             rready;
  fetch_pkg::inst_t rdata;
  logic [1:0]       rresp;
  logic             rvalid;
  logic             rlast;
  int               request_count;

  int value_errors = 0;
  int timeouts = 0;

  always #5 clock = ~clock;

  fetch_top i_dut (.*);

  axi_mem_model i_mem (.*);

  function automatic fetch_pkg::inst_t expected_word(fetch_pkg::addr_t addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  task automatic check_inst(string name, fetch_pkg::inst_t got, fetch_pkg::inst_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_addr(string name, fetch_pkg::addr_t got, fetch_pkg::addr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      value_errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    timeouts++;
    $display("Timeout: %s never went high", what);
  endtask

  task automatic wait_inst_valid();
    int cycles;
    cycles = 0;
    while (!inst_valid && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!inst_valid) begin
      report_timeout("inst_valid");
    end
  endtask

  task automatic wait_arvalid();
    int cycles;
    cycles = 0;
    while (!arvalid && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!arvalid) begin
      report_timeout("arvalid");
    end
  endtask

  // Ends on the falling edge where the word is visible
  task automatic expect_word(fetch_pkg::addr_t pc);
    wait_inst_valid();
    check_inst("inst", inst, expected_word(pc));
    check_addr("ifu_pc", ifu_pc, pc);
  endtask

  task automatic expect_words(fetch_pkg::addr_t first, int count);
    for (int i = 0; i < count; i++) begin
      expect_word(first + 4 * i);
      @(negedge clock);
    end
  endtask

  task automatic expect_request(fetch_pkg::addr_t addr, int len);
    wait_arvalid();
    check_addr("araddr", araddr, addr);
    check_count("arlen", int'(arlen), len);
    check_bit("busy", busy, 1'b1);
  endtask

  task automatic redirect(fetch_pkg::addr_t target, logic flush);
    npc            = target;
    clear_pipeline = 1'b1;
    clear_cache    = flush;
    @(negedge clock);
    clear_pipeline = 1'b0;
    clear_cache    = 1'b0;
  endtask

  task automatic hold_word(fetch_pkg::addr_t pc);
    repeat (3) begin
      @(negedge clock);
      check_bit("inst_valid", inst_valid, 1'b1);
      check_inst("inst", inst, expected_word(pc));
      check_addr("ifu_pc", ifu_pc, pc);
    end
  endtask

  task automatic test_reset_and_fill();
    repeat (8) @(negedge clock);
    reset = 1'b0;
    check_bit("inst_valid", inst_valid, 1'b0);
    check_bit("arvalid", arvalid, 1'b0);
    check_bit("rready", rready, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("inst_addr_misaligned", inst_addr_misaligned, 1'b0);
    check_addr("ifu_pc", ifu_pc, 32'h3000_0000);
    block = 1'b0;
    expect_request(32'h3000_0000, 3);
    expect_words(32'h3000_0000, 4);
    check_count("request_count", request_count, 1);
  endtask

  task automatic test_hits();
    redirect(32'h3000_0000, 1'b0);
    expect_words(32'h3000_0000, 4);
    check_count("request_count", request_count, 1);
    // Flushed line has to be fetched again
    redirect(32'h3000_0000, 1'b1);
    expect_request(32'h3000_0000, 3);
    expect_words(32'h3000_0000, 4);
    check_count("request_count", request_count, 2);
  endtask

  task automatic test_sram_bypass();
    fetch_pkg::addr_t pc;
    redirect(32'h0F00_0010, 1'b0);
    for (int i = 0; i < 3; i++) begin
      pc        = 32'h0F00_0010 + 4 * i;
      npc       = pc;
      npc_valid = 1'b1;
      expect_request(pc, 0);
      expect_word(pc);
    end
    npc_valid = 1'b0;
    check_count("request_count", request_count, 5);
  endtask

  task automatic test_backpressure();
    redirect(32'h3000_0000, 1'b0);
    expect_word(32'h3000_0000);
    idu_ready = 1'b0;
    hold_word(32'h3000_0000);
    idu_ready = 1'b1;
    block     = 1'b1;
    hold_word(32'h3000_0000);
    block = 1'b0;
    @(negedge clock);
    expect_words(32'h3000_0004, 3);
    check_count("request_count", request_count, 5);
  endtask

  task automatic test_misaligned();
    int cycles;
    redirect(32'h3000_0002, 1'b0);
    cycles = 0;
    while (!inst_addr_misaligned && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    check_count("misalign delay", cycles, 4);
    check_bit("inst_addr_misaligned", inst_addr_misaligned, 1'b1);
    check_addr("ifu_pc", ifu_pc, 32'h3000_0002);
    check_bit("inst_valid", inst_valid, 1'b0);
    check_bit("arvalid", arvalid, 1'b0);
    check_count("request_count", request_count, 5);
  endtask

  initial begin
    reset          = 1'b1;
    npc            = '0;
    npc_valid      = 1'b0;
    clear_pipeline = 1'b0;
    clear_cache    = 1'b0;
    idu_ready      = 1'b1;
    block          = 1'b1;
    test_reset_and_fill();
    test_hits();
    test_sram_bypass();
    test_backpressure();
    test_misaligned();
    finish_run();
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/fetch_pkg.sv
hw/axi_read_if.sv
hw/icache_port_if.sv
hw/icache_array.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
dv/axi_mem_model.sv
dv/fetch_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f src.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	@grep -q "^NO ERRORS$$" sim.log || (echo "Simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
